// File: source/shared_tlb_defs.svh
//////////////////////////////////////////////////
// sizing constants for the shared TLB
// include wherever the set count, way count or
// ASID width is needed
//////////////////////////////////////////////////

`ifndef SHARED_TLB_DEFS_SVH
`define SHARED_TLB_DEFS_SVH

// number of sets
`define SHARED_TLB_DEPTH 16

// associativity
`define SHARED_TLB_WAYS 2

`define ASID_WIDTH 16

// set index bits, log2 of the depth
`define SHARED_TLB_IDX_W 4

`endif

// File: source/shared_tlb_pkg.sv
//////////////////////////////////////////////////
// types shared by the shared TLB, its RAMs, the
// victim selector and the testbench
// Sv39 address, PTE, tag and refill records
//////////////////////////////////////////////////

`include "shared_tlb_defs.svh"

package shared_tlb_pkg;

    typedef logic [38:0] vaddr_t;      // sv39 virtual address
    typedef logic [26:0] vpn_t;        // vpn2, vpn1, vpn0
    typedef logic [8:0]  vpn_part_t;   // one level of the vpn
    typedef logic [43:0] ppn_t;
    typedef logic [`ASID_WIDTH-1:0] asid_t;

    // way bookkeeping
    typedef logic [$clog2(`SHARED_TLB_WAYS)-1:0] way_idx_t;
    typedef logic [`SHARED_TLB_WAYS-1:0]         way_mask_t;

    // sv39 page table entry, 64 bits
    typedef struct packed {
        logic [9:0] reserved;
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;           // global, matches any asid
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    // tag word, valid bits live in flops
    typedef struct packed {
        asid_t     asid;
        vpn_part_t vpn2;
        vpn_part_t vpn1;
        vpn_part_t vpn0;
        logic      is_2M;
        logic      is_1G;
    } tag_t;

    // refill record, walker to shared TLB and shared TLB to i/d TLB
    typedef struct packed {
        logic  valid;
        logic  is_2M;
        logic  is_1G;
        vpn_t  vpn;
        asid_t asid;
        pte_t  content;
    } tlb_update_t;

endpackage

// File: source/tlb_way_ram.sv
//////////////////////////////////////////////////
// single-port synchronous RAM for one TLB way
// holds either the tags or the PTEs of that way
// read data shows up the cycle after req_i
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tlb_way_ram #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned NUM_WORDS  = 64
) (
    input  logic                         clk_i,
    input  logic                         req_i,    // access this cycle
    input  logic                         we_i,     // write when set, read otherwise
    input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0]        wdata_i,
    output logic [DATA_WIDTH-1:0]        rdata_o
);

    logic [DATA_WIDTH-1:0] mem_q [NUM_WORDS];
    logic [DATA_WIDTH-1:0] rdata_q;

    //////////////////////////////////////////////////
    // array access
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;  // rdata_q keeps the last read
            end else begin
                rdata_q <= mem_q[addr_i];
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: source/tlb_victim_sel.sv
//////////////////////////////////////////////////
// replacement way selection for the shared TLB
// lowest invalid way first, pseudo random way
// from an 8-bit LFSR once the set is full
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "shared_tlb_defs.svh"

module tlb_victim_sel import shared_tlb_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      update_i,     // refill write this cycle
    input  way_mask_t set_valid_i,  // valid bits of the target set
    output way_mask_t victim_o      // one-hot, zero without update
);

    localparam logic [7:0] LFSR_SEED = 8'hA5;

    logic [7:0] lfsr_q;
    logic       lfsr_fb;
    logic       all_valid;
    logic       step_lfsr;
    way_idx_t   inv_way;    // lowest free way
    way_idx_t   rnd_way;
    way_idx_t   repl_way;

    //////////////////////////////////////////////////
    // free way scan
    //////////////////////////////////////////////////

    // walk down so the lowest free way is the last one written
    always_comb begin : inv_scan
        inv_way = '0;
        for (int i = `SHARED_TLB_WAYS - 1; i >= 0; i--) begin
            if (!set_valid_i[i]) begin
                inv_way = way_idx_t'(i);
            end
        end
    end

    assign all_valid = &set_valid_i;

    //////////////////////////////////////////////////
    // fibonacci lfsr, x^8 + x^6 + x^5 + x^4 + 1
    //////////////////////////////////////////////////

    assign lfsr_fb   = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
    assign step_lfsr = update_i & all_valid;     // only random picks consume it
    assign rnd_way   = lfsr_q[$bits(way_idx_t)-1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lfsr_q <= LFSR_SEED;
        end else if (step_lfsr) begin
            lfsr_q <= {lfsr_q[6:0], lfsr_fb};
        end
    end

    assign repl_way = all_valid ? rnd_way : inv_way;

    always_comb begin : victim_oh
        victim_o = '0;
        if (update_i) begin
            victim_o[repl_way] = 1'b1;
        end
    end

    // a zero state would lock the sequence
    a_lfsr_nonzero : assert property (@(posedge clk_i) disable iff (!rst_ni)
        lfsr_q != '0);

endmodule

// File: source/shared_tlb.sv
//////////////////////////////////////////////////
// set-associative shared TLB behind the ITLB and
// DTLB of an Sv39 core
// looks up first-level misses, answers with a
// refill record one cycle later, filled by the
// page-table walker through shared_tlb_update_i
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "shared_tlb_defs.svh"

module shared_tlb import shared_tlb_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        flush_i,                 // drop every entry
    input  logic        enable_translation_i,    // sv39 on for fetch
    input  logic        en_ld_st_translation_i,  // sv39 on for loads and stores
    input  asid_t       asid_i,

    // ITLB request
    input  logic        itlb_access_i,
    input  logic        itlb_hit_i,
    input  vaddr_t      itlb_vaddr_i,

    // DTLB request
    input  logic        dtlb_access_i,
    input  logic        dtlb_hit_i,
    input  vaddr_t      dtlb_vaddr_i,

    // refills back to the first-level TLBs
    output tlb_update_t itlb_update_o,
    output tlb_update_t dtlb_update_o,

    // status and perf counter strobes
    output logic        itlb_miss_o,
    output logic        dtlb_miss_o,
    output logic        shared_tlb_access_o,
    output logic        shared_tlb_hit_o,
    output vaddr_t      shared_tlb_vaddr_o,
    output logic        itlb_req_o,

    // writes from the page-table walker
    input  tlb_update_t shared_tlb_update_i
);

    localparam int unsigned WAYS  = `SHARED_TLB_WAYS;
    localparam int unsigned IDX_W = `SHARED_TLB_IDX_W;

    // request side
    logic             lookup;
    vaddr_t           lkp_vaddr;
    logic [IDX_W-1:0] rd_idx;

    // lookup stage
    logic             access_q;
    logic             itlb_req_q;
    logic             dtlb_req_q;
    vaddr_t           vaddr_q;
    asid_t            asid_q;
    way_mask_t        set_valid_q;    // valid bits of the looked-up set
    vpn_part_t        lkp_vpn2;
    vpn_part_t        lkp_vpn1;
    vpn_part_t        lkp_vpn0;

    // entry state
    way_mask_t [`SHARED_TLB_DEPTH-1:0] valid_q;
    way_mask_t        upd_set_valid;
    way_mask_t        victim;
    logic [IDX_W-1:0] wr_idx;
    tag_t             tag_wr;

    // RAM side
    logic [IDX_W-1:0] ram_addr;
    way_mask_t        ram_req;
    tag_t [WAYS-1:0]  tag_rd;
    pte_t [WAYS-1:0]  pte_rd;

    // compare and refill
    way_mask_t        way_hit;
    tlb_update_t      refill;

    //////////////////////////////////////////////////
    // miss capture
    //////////////////////////////////////////////////

    // a data access in the same cycle holds off the fetch side
    assign dtlb_miss_o = en_ld_st_translation_i & dtlb_access_i & ~dtlb_hit_i;
    assign itlb_miss_o = enable_translation_i & itlb_access_i & ~itlb_hit_i
                         & ~dtlb_access_i;

    assign lookup    = itlb_miss_o | dtlb_miss_o;
    assign lkp_vaddr = dtlb_miss_o ? dtlb_vaddr_i : itlb_vaddr_i;
    assign rd_idx    = lkp_vaddr[12 +: IDX_W];    // low vpn0 bits pick the set

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            access_q    <= 1'b0;
            itlb_req_q  <= 1'b0;
            dtlb_req_q  <= 1'b0;
            set_valid_q <= '0;
            vaddr_q     <= '0;
        end else begin
            access_q    <= lookup;
            itlb_req_q  <= itlb_miss_o;
            dtlb_req_q  <= dtlb_miss_o;
            set_valid_q <= lookup ? valid_q[rd_idx] : '0;   // no access, no hit
            if (lookup) begin
                vaddr_q <= lkp_vaddr;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup) begin
            asid_q <= asid_i;
        end
    end

    assign lkp_vpn2 = vaddr_q[38:30];
    assign lkp_vpn1 = vaddr_q[29:21];
    assign lkp_vpn0 = vaddr_q[20:12];

    assign shared_tlb_access_o = access_q;
    assign shared_tlb_vaddr_o  = vaddr_q;
    assign itlb_req_o          = itlb_req_q;

    //////////////////////////////////////////////////
    // tag compare and refill record
    //////////////////////////////////////////////////

    always_comb begin : tag_compare
        way_hit = '0;
        for (int unsigned i = 0; i < WAYS; i++) begin
            if (set_valid_q[i] && (asid_q == tag_rd[i].asid || pte_rd[i].g)
                && lkp_vpn2 == tag_rd[i].vpn2) begin
                if (tag_rd[i].is_1G) begin
                    way_hit[i] = 1'b1;             // gigapage ignores vpn1 and vpn0
                end else if (lkp_vpn1 == tag_rd[i].vpn1
                             && (tag_rd[i].is_2M || lkp_vpn0 == tag_rd[i].vpn0)) begin
                    way_hit[i] = 1'b1;
                end
            end
        end
    end

    // lowest hitting way wins if two ever match
    always_comb begin : refill_build
        refill = '0;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (way_hit[i]) begin
                refill.valid   = 1'b1;
                refill.is_2M   = tag_rd[i].is_2M;
                refill.is_1G   = tag_rd[i].is_1G;
                refill.vpn     = vaddr_q[38:12];
                refill.asid    = asid_q;
                refill.content = pte_rd[i];
            end
        end
    end

    assign shared_tlb_hit_o = |way_hit;
    assign itlb_update_o    = itlb_req_q ? refill : '0;
    assign dtlb_update_o    = dtlb_req_q ? refill : '0;

    //////////////////////////////////////////////////
    // update and flush
    //////////////////////////////////////////////////

    assign wr_idx        = shared_tlb_update_i.vpn[IDX_W-1:0];
    assign upd_set_valid = valid_q[wr_idx];

    tlb_victim_sel i_victim_sel (
        .clk_i       ( clk_i                     ),
        .rst_ni      ( rst_ni                    ),
        .update_i    ( shared_tlb_update_i.valid ),
        .set_valid_i ( upd_set_valid             ),
        .victim_o    ( victim                    )
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;                          // flush beats a same-cycle update
        end else if (shared_tlb_update_i.valid) begin
            valid_q[wr_idx] <= valid_q[wr_idx] | victim;
        end
    end

    assign tag_wr.asid  = shared_tlb_update_i.asid;
    assign tag_wr.vpn2  = shared_tlb_update_i.vpn[26:18];
    assign tag_wr.vpn1  = shared_tlb_update_i.vpn[17:9];
    assign tag_wr.vpn0  = shared_tlb_update_i.vpn[8:0];
    assign tag_wr.is_2M = shared_tlb_update_i.is_2M;
    assign tag_wr.is_1G = shared_tlb_update_i.is_1G;

    //////////////////////////////////////////////////
    // way RAMs
    //////////////////////////////////////////////////

    assign ram_req  = victim | {WAYS{lookup}};
    assign ram_addr = shared_tlb_update_i.valid ? wr_idx : rd_idx;   // write first

    for (genvar i = 0; i < WAYS; i++) begin : gen_way
        tlb_way_ram #(
            .DATA_WIDTH ( $bits(tag_t)      ),
            .NUM_WORDS  ( `SHARED_TLB_DEPTH )
        ) i_tag_ram (
            .clk_i   ( clk_i      ),
            .req_i   ( ram_req[i] ),
            .we_i    ( victim[i]  ),
            .addr_i  ( ram_addr   ),
            .wdata_i ( tag_wr     ),
            .rdata_o ( tag_rd[i]  )
        );

        tlb_way_ram #(
            .DATA_WIDTH ( $bits(pte_t)      ),
            .NUM_WORDS  ( `SHARED_TLB_DEPTH )
        ) i_pte_ram (
            .clk_i   ( clk_i                       ),
            .req_i   ( ram_req[i]                  ),
            .we_i    ( victim[i]                   ),
            .addr_i  ( ram_addr                    ),
            .wdata_i ( shared_tlb_update_i.content ),
            .rdata_o ( pte_rd[i]                   )
        );
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // walker writes and lookups share the RAM port
    a_no_update_on_lookup : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(shared_tlb_update_i.valid && lookup));

    // a set with room gets its lowest free way
    a_victim_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
        shared_tlb_update_i.valid |-> $onehot(victim)
            && ((&upd_set_valid) || ((victim & upd_set_valid) == '0
            && ((victim - 1'b1) & ~upd_set_valid) == '0)));

    a_single_refill : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(itlb_update_o.valid && dtlb_update_o.valid));

endmodule

// File: verification/shared_tlb_tb.sv
//////////////////////////////////////////////////
// testbench for the shared TLB
// replays the operations of the tests file, one
// per clock, and checks strobes and refill records
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "shared_tlb_defs.svh"

module shared_tlb_tb import shared_tlb_pkg::*; ();

    localparam string TEST_FILE  = "verification/shared_tlb_tests.txt";
    localparam int    CLK_PERIOD = 40;

    // everything the TB drives into the DUT
    typedef struct packed {
        logic        rst_n;
        logic        flush;
        logic        en;            // fetch and load/store translation
        asid_t       asid;
        logic        itlb_access;
        logic        dtlb_access;
        vaddr_t      itlb_vaddr;
        vaddr_t      dtlb_vaddr;    // the idle side gets another page
        tlb_update_t upd;
    } stim_t;

    // one parsed line and what it expects
    typedef struct packed {
        logic [7:0] op;
        logic       miss;           // own miss strobe
        logic       other;          // miss strobe of the other TLB
        logic [1:0] hit;            // 0 miss, 1 hit, 2 count only
        logic [3:0] slot;
        vaddr_t     vaddr;
        asid_t      asid;
        logic [7:0] cnt;
    } line_t;

    logic        clk = 1'b0;
    stim_t       drv = '0;
    stim_t       nxt = '0;
    tlb_update_t itlb_update;
    tlb_update_t dtlb_update;
    logic        itlb_miss;
    logic        dtlb_miss;
    logic        tlb_access;
    logic        tlb_hit;
    vaddr_t      tlb_vaddr;
    logic        itlb_req;

    pte_t             pte_tab [16];     // PTE written per slot
    logic             size_2m [16];
    logic             size_1g [16];
    integer           seed;
    int               fd;
    int               n_lines = 0;
    int               errors = 0;
    int               hit_cnt = 0;
    logic [8*128-1:0] junk;

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        drv <= nxt;
    end

    shared_tlb DUT (
        .clk_i                  ( clk         ),
        .rst_ni                 ( drv.rst_n   ),
        .flush_i                ( drv.flush   ),
        .enable_translation_i   ( drv.en      ),
        .en_ld_st_translation_i ( drv.en      ),
        .asid_i                 ( drv.asid    ),
        .itlb_access_i          ( drv.itlb_access ),
        .itlb_hit_i             ( 1'b0        ),
        .itlb_vaddr_i           ( drv.itlb_vaddr ),
        .dtlb_access_i          ( drv.dtlb_access ),
        .dtlb_hit_i             ( 1'b0        ),
        .dtlb_vaddr_i           ( drv.dtlb_vaddr ),
        .itlb_update_o          ( itlb_update ),
        .dtlb_update_o          ( dtlb_update ),
        .itlb_miss_o            ( itlb_miss   ),
        .dtlb_miss_o            ( dtlb_miss   ),
        .shared_tlb_access_o    ( tlb_access  ),
        .shared_tlb_hit_o       ( tlb_hit     ),
        .shared_tlb_vaddr_o     ( tlb_vaddr   ),
        .itlb_req_o             ( itlb_req    ),
        .shared_tlb_update_i    ( drv.upd     )
    );

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        errors++;
        $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
    endtask

    //////////////////////////////////////////////////
    // tests file parsing
    //////////////////////////////////////////////////

    task automatic read_line(output line_t ln, output stim_t st, output logic done);
        logic [7:0]  op;
        logic [3:0]  slot;
        logic [26:0] vpn;
        asid_t       asid;
        logic        en;
        logic        both;
        logic        miss;
        logic        is_2m;
        logic        is_1g;
        logic        g;
        logic [1:0]  hit;
        logic [19:0] ppn_lo;
        vaddr_t      vaddr;
        logic [7:0]  cnt;
        logic [31:0] r0;
        logic [31:0] r1;
        pte_t        pte;
        int          n;
        ln = '0;
        st = '0;
        st.rst_n = 1'b1;
        done = 1'b0;
        op = "#";
        while (op == "#") begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) begin
                done = 1'b1;        // end of file so idle from here on
                op = "N";
            end else if (op == "#") begin
                n = $fgets(junk, fd);
            end
        end
        ln.op = op;
        case (op)
            "U": begin
                n = $fscanf(fd, "%d %h %h %d %d %d %h", slot, vpn, asid, is_2m, is_1g, g,
                            ppn_lo);
                if (n != 7) begin
                    errors++;
                    $display("malformed update line in the tests file");
                end
                r0 = $random(seed);
                r1 = $random(seed);
                pte = '0;
                pte.reserved = r0[9:0];
                pte.ppn = {r1[23:0], ppn_lo};   // upper ppn bits are don't care
                pte.rsw = r0[11:10];
                pte.d = r0[12];
                pte.a = r0[13];
                pte.u = r0[14];
                pte.x = r0[15];
                pte.w = r0[16];
                pte.r = r0[17];
                pte.g = g;
                pte.v = 1'b1;
                pte_tab[slot] = pte;
                size_2m[slot] = is_2m;
                size_1g[slot] = is_1g;
                st.upd.valid = 1'b1;
                st.upd.is_2M = is_2m;
                st.upd.is_1G = is_1g;
                st.upd.vpn = vpn;
                st.upd.asid = asid;
                st.upd.content = pte;
            end
            "I", "D": begin
                n = $fscanf(fd, "%h %h %d %d %d %d %d", vaddr, asid, en, both, miss, hit, slot);
                if (n != 7) begin
                    errors++;
                    $display("malformed lookup line in the tests file");
                end
                st.en = en;
                st.asid = asid;
                st.itlb_vaddr = (op == "I") ? vaddr : ~vaddr;
                st.dtlb_vaddr = ((op == "D") | both) ? vaddr : ~vaddr;
                st.itlb_access = (op == "I") | both;
                st.dtlb_access = (op == "D") | both;
                ln.miss = miss;
                ln.other = (op == "I") & both & en;   // a data access is never blocked
                ln.hit = hit;
                ln.slot = slot;
                ln.vaddr = vaddr;
                ln.asid = asid;
            end
            "C": begin
                n = $fscanf(fd, "%d", cnt);
                if (n != 1) begin
                    errors++;
                    $display("malformed count line in the tests file");
                end
                ln.cnt = cnt;
            end
            "F": st.flush = 1'b1;
            "N": ;
            default: begin
                errors++;
                $display("unknown operation %c in the tests file", op);
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // combinational strobes of the line applied this cycle
    task automatic check_strobes(input line_t c);
        logic exp_i;
        logic exp_d;
        exp_i = (c.op == "I") ? c.miss : c.other;
        exp_d = (c.op == "D") ? c.miss : c.other;
        if (itlb_miss !== exp_i) report_mismatch("itlb_miss_o", 64'(exp_i), 64'(itlb_miss));
        if (dtlb_miss !== exp_d) report_mismatch("dtlb_miss_o", 64'(exp_d), 64'(dtlb_miss));
        if (c.op == "C") begin
            if (hit_cnt != int'(c.cnt)) report_mismatch("hit count", 64'(c.cnt), 64'(hit_cnt));
            hit_cnt = 0;
        end
    endtask

    // registered results of the line applied one cycle earlier
    task automatic verify_result(input line_t p);
        logic        exp_acc;
        logic        exp_hit;
        logic        is_i;
        tlb_update_t own;
        tlb_update_t other;
        string       own_name;
        exp_acc = p.miss | p.other;
        is_i = (p.op == "I") & ~p.other;    // a blocked fetch leaves the data side served
        own = is_i ? itlb_update : dtlb_update;
        other = is_i ? dtlb_update : itlb_update;
        own_name = is_i ? "itlb_update_o" : "dtlb_update_o";
        if (tlb_access !== exp_acc) begin
            report_mismatch("shared_tlb_access_o", 64'(exp_acc), 64'(tlb_access));
        end
        if (exp_acc && tlb_vaddr !== p.vaddr) begin
            report_mismatch("shared_tlb_vaddr_o", 64'(p.vaddr), 64'(tlb_vaddr));
        end
        if (itlb_req !== (is_i & p.miss)) report_mismatch("itlb_req_o", 64'(is_i & p.miss),
                                                          64'(itlb_req));
        if (other.valid !== 1'b0) report_mismatch("update valid of the other TLB", 64'(0),
                                                  64'(other.valid));
        if (p.hit == 2'd2) begin
            if (tlb_hit === 1'b1) hit_cnt++;  // way choice left to the LFSR
        end else begin
            exp_hit = exp_acc & p.hit[0];
            if (tlb_hit !== exp_hit) report_mismatch("shared_tlb_hit_o", 64'(exp_hit),
                                                     64'(tlb_hit));
            if (own.valid !== exp_hit) report_mismatch({own_name, ".valid"}, 64'(exp_hit),
                                                       64'(own.valid));
            if (exp_hit) begin
                if (own.vpn !== p.vaddr[38:12]) begin
                    report_mismatch({own_name, ".vpn"}, 64'(p.vaddr[38:12]), 64'(own.vpn));
                end
                if (own.asid !== p.asid) begin
                    report_mismatch({own_name, ".asid"}, 64'(p.asid), 64'(own.asid));
                end
                if ({own.is_2M, own.is_1G} !== {size_2m[p.slot], size_1g[p.slot]}) begin
                    report_mismatch({own_name, " size flags"},
                                    64'({size_2m[p.slot], size_1g[p.slot]}),
                                    64'({own.is_2M, own.is_1G}));
                end
                if (own.content !== pte_tab[p.slot]) begin
                    report_mismatch({own_name, ".content"}, pte_tab[p.slot], own.content);
                end
            end
        end
    endtask

    task automatic run_tests();
        line_t cur;
        line_t prev;
        stim_t st;
        logic  done;
        int    drain;
        cur = '0;
        cur.op = "N";
        prev = cur;
        drain = 2;
        repeat (4) @(negedge clk);
        nxt.rst_n = 1'b1;
        while (drain > 0) begin
            @(negedge clk);
            verify_result(prev);
            check_strobes(cur);
            prev = cur;
            read_line(cur, st, done);
            nxt = st;
            if (done) drain--;
        end
    endtask

    initial begin : main
        seed = 22730;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the tests file %s", TEST_FILE);
        end else begin
            while ($fgets(junk, fd) != 0) n_lines++;
            $fclose(fd);
            fd = $fopen(TEST_FILE, "r");
            run_tests();
            $fclose(fd);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // limit grows with the length of the tests file
    initial begin : watchdog
        wait (n_lines > 0);
        #((n_lines + 20) * 4 * CLK_PERIOD);
        $display("timeout, the test sequence did not finish in time");
        $display("sim failed");
        $finish;
    end

endmodule

// File: verification/shared_tlb_tests.txt
# U slot vpn asid is_2M is_1G g ppn_lo | F flush | N idle | C expected_hit_count
# I/D vaddr asid en both miss hit(0 no,1 yes,2 count) slot ; set = vaddr[15:12]
U 0 0012345 0001 0 0 0 11111
U 1 0040007 0003 0 0 1 22222
U 2 0A00003 0004 1 0 0 33333
U 3 1400006 0004 0 1 0 aaaaa
N
# hit and refill on both sides
I 0012345abc 0001 1 0 1 1 0
N
D 0012345010 0001 1 0 1 1 0
# 4K page, other vpn0 in the same set
I 0012355000 0001 1 0 1 0 0
I 0012345000 0002 1 0 1 0 0
I 0040007000 0009 1 0 1 1 1
# 2M hits for other vpn0 upper bits, misses for other vpn1
I 0A001F3000 0004 1 0 1 1 2
I 0A00203000 0004 1 0 1 0 2
# 1G hits for other vpn1 and vpn0
D 1435A36000 0004 1 0 1 1 3
D 1835A36000 0004 1 0 1 0 3
N
# fetch blocked by a data access
D 0040007123 0009 1 1 1 1 1
N
# back to back lookups
I 0012345abc 0001 1 0 1 1 0
D 1435A36000 0004 1 0 1 1 3
I 0A00203000 0004 1 0 1 0 2
N
# translation off
I 0012345abc 0001 0 0 0 0 0
D 0012345abc 0001 0 0 0 0 0
F
I 0012345abc 0001 1 0 1 0 0
D 1435A36000 0004 1 0 1 0 3
# replacement in set 9
U 4 0000009 0005 0 0 0 44444
U 5 0000019 0005 0 0 0 55555
I 0000009000 0005 1 0 1 1 4
I 0000019000 0005 1 0 1 1 5
U 6 0000029 0005 0 0 0 66666
I 0000029000 0005 1 0 1 1 6
I 0000009000 0005 1 0 1 2 0
I 0000019000 0005 1 0 1 2 0
C 1
N

// File: src.f
+incdir+source
source/shared_tlb_pkg.sv
source/tlb_way_ram.sv
source/tlb_victim_sel.sv
source/shared_tlb.sv
verification/shared_tlb_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the shared TLB testbench with Verilator, run it, then check the log

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f src.f --top-module shared_tlb_tb \
    -o shared_tlb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/shared_tlb_sim > sim.log 2>&1
cat sim.log

grep -qx "sim passed" sim.log && echo "result: PASS" || { echo "result: FAIL"; exit 1; }
